// ==== core_ctrl.sv ====
`timescale 1ns/1ps

module core_ctrl
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  logic       halt_seen_i,
    input  logic       ex_busy_i,
    output imem_addr_t pc_o,
    output logic       fetch_en_o,
    output logic       if_valid_o,
    output logic       flush_o,
    output logic       halted_o
);

    core_state_e state_q;
    core_state_e state_d;
    imem_addr_t  pc_q;
    logic        if_valid_q;
    logic        start_ok;

    assign start_ok = start_i && ((state_q == ST_IDLE) || (state_q == ST_HALT));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_HALT: begin
                if (start_ok) begin
                    state_d = ST_RUN;
                end
            end
            ST_RUN: begin
                if (halt_seen_i) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (!ex_busy_i) begin  // last older instr written
                    state_d = ST_HALT;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            pc_q       <= '0;
            if_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            if_valid_q <= fetch_en_o;
            if (start_ok) begin
                pc_q <= '0;
            end else if (fetch_en_o) begin
                pc_q <= pc_q + 1'b1;
            end
        end
    end

    // stop fetching in the cycle ecall is decoded
    assign fetch_en_o = (state_q == ST_RUN) && !halt_seen_i;
    assign flush_o    = halt_seen_i || (state_q != ST_RUN);
    assign pc_o       = pc_q;
    assign if_valid_o = if_valid_q;
    assign halted_o   = (state_q == ST_HALT);

endmodule

// ==== ex.sv ====
`timescale 1ns/1ps

module ex
    import rv_isa_pkg::*;
(
    input  word_t     inst_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  reg_addr_t rd_addr_i,
    input  logic      reg_wen_i,
    input  logic      valid_i,
    output word_t     rd_wdata_o,
    output reg_addr_t rd_waddr_o,
    output logic      reg_wen_o
);

    opcode_t opcode;
    func3_t  func3;
    func7_t  func7;

    assign opcode = inst_i[6:0];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];

    always_comb begin
        rd_wdata_o = '0;
        rd_waddr_o = '0;
        reg_wen_o  = 1'b0;
        if (valid_i) begin
            case (opcode)
                OPC_TYPE_I: begin
                    if (func3 == F3_ADDI) begin
                        rd_wdata_o = op1_i + op2_i;
                        rd_waddr_o = rd_addr_i;
                        reg_wen_o  = reg_wen_i;
                    end
                end
                OPC_TYPE_R: begin
                    if (func3 == F3_ADD_SUB) begin
                        if (func7 == F7_ADD) begin
                            rd_wdata_o = op1_i + op2_i;
                            rd_waddr_o = rd_addr_i;
                            reg_wen_o  = reg_wen_i;
                        end else if (func7 == F7_SUB) begin
                            rd_wdata_o = op1_i - op2_i;  // rs1 - rs2
                            rd_waddr_o = rd_addr_i;
                            reg_wen_o  = reg_wen_i;
                        end
                    end
                end
                default: begin
                    // unsupported, retires without write
                    reg_wen_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== id.sv ====
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module id
    import rv_isa_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  word_t     inst_i,
    input  logic      inst_valid_i,
    input  logic      flush_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output logic      halt_seen_o,
    output word_t     inst_o,
    output word_t     op1_o,
    output word_t     op2_o,
    output reg_addr_t rd_addr_o,
    output logic      reg_wen_o,
    output logic      valid_o
);

    opcode_t   opcode;
    func3_t    func3;
    func7_t    func7;
    imm_i_t    imm;
    reg_addr_t rd;
    word_t     op2;
    logic      supported;
    logic      wen;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign func3  = inst_i[14:12];
    assign func7  = inst_i[31:25];
    assign imm    = inst_i[31:20];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign supported = ((opcode == OPC_TYPE_I) && (func3 == F3_ADDI)) ||
                       ((opcode == OPC_TYPE_R) && (func3 == F3_ADD_SUB) &&
                        ((func7 == F7_ADD) || (func7 == F7_SUB)));
    assign wen = supported && (rd != '0);   // x0 writes dropped here

    // imm for op-imm, rs2 otherwise
    assign op2 = (opcode == OPC_TYPE_I) ? {{(`XLEN-`IMM_I_W){imm[`IMM_I_W-1]}}, imm}
                                        : rs2_data_i;

    assign halt_seen_o = inst_valid_i && (inst_i == INST_ECALL);

    // id_ex control
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o   <= 1'b0;
            reg_wen_o <= 1'b0;
        end else begin
            valid_o   <= inst_valid_i && !flush_i;  // ecall is flushed here
            reg_wen_o <= inst_valid_i && !flush_i && wen;
        end
    end

    // id_ex payload
    always_ff @(posedge clk_i) begin
        inst_o    <= inst_i;
        op1_o     <= rs1_data_i;
        op2_o     <= op2;
        rd_addr_o <= rd;
    end

endmodule

// ==== imem.sv ====
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module imem
    import rv_isa_pkg::*;
(
    input  logic       clk_i,
    input  logic       we_i,
    input  imem_addr_t waddr_i,
    input  word_t      wdata_i,
    input  logic       re_i,
    input  imem_addr_t raddr_i,
    output word_t      rdata_o
);

    word_t mem [`IMEM_DEPTH];
    word_t rdata_q;

    // program load, only while the core is idle
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // fetch read, output holds when not enabled
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_q <= mem[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== regs.sv ====
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module regs
    import rv_isa_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o,
    input  reg_addr_t dbg_raddr_i,
    output word_t     dbg_rdata_o
);

    word_t rf_q [`REG_NUM];

    // decode read with write-through from ex
    function automatic word_t read_fwd(input reg_addr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we_i && (waddr_i == addr)) begin
            val = wdata_i;   // same cycle write
        end else begin
            val = rf_q[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            rf_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o    = read_fwd(raddr1_i);
    assign rdata2_o    = read_fwd(raddr2_i);
    assign dbg_rdata_o = rf_q[dbg_raddr_i];

endmodule

// ==== rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// datapath width
`define XLEN 32

// x0..x31
`define REG_ADDR_W 5
`define REG_NUM (1 << `REG_ADDR_W)

// instruction memory, word addressed
`define IMEM_AW 6
`define IMEM_DEPTH (1 << `IMEM_AW)

// immediate field of I-type
`define IMM_I_W 12

`endif

// ==== rv_core_sva.sv ====
`timescale 1ns/1ps

module rv_core_sva
    import rv_isa_pkg::*;
(
    input logic      clk_i,
    input logic      arst_n_i,
    input logic      start_i,
    input logic      imem_we_i,
    input reg_addr_t dbg_raddr_i,
    input word_t     dbg_rdata_i,
    input logic      halted_i,
    input logic      fetch_en_i,
    input logic      if_valid_i,
    input logic      ex_valid_i
);

    logic started_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q <= 1'b0;
        end else if (start_i) begin
            started_q <= 1'b1;
        end
    end

    halt_before_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !started_q |-> !halted_i)
        else $error("halted_o high before any start");

    // any stage busy counts as running
    load_while_running: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        imem_we_i |-> !(fetch_en_i || if_valid_i || ex_valid_i))
        else $error("imem written while the core is running");

    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (dbg_raddr_i == '0) |-> (dbg_rdata_i == '0))
        else $error("debug read of x0 is not zero");

    no_halt_after_start: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        start_i |=> !halted_i)
        else $error("halted_o high in the cycle after start");

endmodule

bind rv_core_top rv_core_sva rv_core_sva_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .start_i     (start_i),
    .imem_we_i   (imem_we_i),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_i (dbg_rdata_o),
    .halted_i    (halted_o),
    .fetch_en_i  (fetch_en),
    .if_valid_i  (if_valid),
    .ex_valid_i  (ex_valid)
);

// ==== rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top
    import rv_isa_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  logic       imem_we_i,
    input  imem_addr_t imem_waddr_i,
    input  word_t      imem_wdata_i,
    input  reg_addr_t  dbg_raddr_i,
    output word_t      dbg_rdata_o,
    output logic       halted_o
);

    imem_addr_t pc;
    logic       fetch_en;
    logic       if_valid;
    logic       flush;
    logic       halt_seen;
    word_t      if_inst;

    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_data;
    word_t      rs2_data;

    // id_ex stage
    word_t      ex_inst;
    word_t      ex_op1;
    word_t      ex_op2;
    reg_addr_t  ex_rd_addr;
    logic       ex_reg_wen;
    logic       ex_valid;

    // write-back
    word_t      wb_wdata;
    reg_addr_t  wb_waddr;
    logic       wb_wen;

    core_ctrl core_ctrl_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_i     (start_i),
        .halt_seen_i (halt_seen),
        .ex_busy_i   (ex_valid),
        .pc_o        (pc),
        .fetch_en_o  (fetch_en),
        .if_valid_o  (if_valid),
        .flush_o     (flush),
        .halted_o    (halted_o)
    );

    imem imem_i (
        .clk_i   (clk_i),
        .we_i    (imem_we_i),
        .waddr_i (imem_waddr_i),
        .wdata_i (imem_wdata_i),
        .re_i    (fetch_en),
        .raddr_i (pc),
        .rdata_o (if_inst)
    );

    id id_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_i       (if_inst),
        .inst_valid_i (if_valid),
        .flush_i      (flush),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .halt_seen_o  (halt_seen),
        .inst_o       (ex_inst),
        .op1_o        (ex_op1),
        .op2_o        (ex_op2),
        .rd_addr_o    (ex_rd_addr),
        .reg_wen_o    (ex_reg_wen),
        .valid_o      (ex_valid)
    );

    ex ex_i (
        .inst_i     (ex_inst),
        .op1_i      (ex_op1),
        .op2_i      (ex_op2),
        .rd_addr_i  (ex_rd_addr),
        .reg_wen_i  (ex_reg_wen),
        .valid_i    (ex_valid),
        .rd_wdata_o (wb_wdata),
        .rd_waddr_o (wb_waddr),
        .reg_wen_o  (wb_wen)
    );

    regs regs_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .we_i        (wb_wen),
        .waddr_i     (wb_waddr),
        .wdata_i     (wb_wdata),
        .raddr1_i    (rs1_addr),
        .raddr2_i    (rs2_addr),
        .rdata1_o    (rs1_data),
        .rdata2_o    (rs2_data),
        .dbg_raddr_i (dbg_raddr_i),
        .dbg_rdata_o (dbg_rdata_o)
    );

endmodule

// ==== rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,  // waiting for start
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2,  // ecall seen, letting ex retire
        ST_HALT  = 2'd3
    } core_state_e;

endpackage

// ==== rv_isa_pkg.sv ====
`include "rv_core_cfg.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`IMEM_AW-1:0]    imem_addr_t;

    // instruction fields
    typedef logic [6:0]             opcode_t;
    typedef logic [2:0]             func3_t;
    typedef logic [6:0]             func7_t;
    typedef logic [`IMM_I_W-1:0]    imm_i_t;

    localparam opcode_t OPC_TYPE_I = 7'b0010011; // op-imm
    localparam opcode_t OPC_TYPE_R = 7'b0110011; // op

    localparam func3_t  F3_ADDI    = 3'b000;
    localparam func3_t  F3_ADD_SUB = 3'b000;

    localparam func7_t  F7_ADD     = 7'b0000000;
    localparam func7_t  F7_SUB     = 7'b0100000;

    // ecall, all other fields zero
    localparam word_t   INST_ECALL = 32'h0000_0073;

endpackage

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

`include "rv_core_cfg.svh"

module tb_rv_core
    import rv_isa_pkg::*;
();

    localparam int    RUN_TIMEOUT = 400;           // cycles from start to halt
    localparam word_t ECALL_WORD  = 32'h0000_0073;

    logic       clk_i;
    logic       arst_n_i;
    logic       start_i;
    logic       imem_we_i;
    imem_addr_t imem_waddr_i;
    word_t      imem_wdata_i;
    reg_addr_t  dbg_raddr_i;
    word_t      dbg_rdata_o;
    logic       halted_o;

    word_t       prog [`IMEM_DEPTH];
    int          prog_len;
    word_t       model_rf [`REG_NUM];
    logic [31:0] rng_state;
    int          check_cnt;
    int          err_cnt;
    int          timeout_cnt;

    rv_core_top rv_core_top_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .start_i      (start_i),
        .imem_we_i    (imem_we_i),
        .imem_waddr_i (imem_waddr_i),
        .imem_wdata_i (imem_wdata_i),
        .dbg_raddr_i  (dbg_raddr_i),
        .dbg_rdata_o  (dbg_rdata_o),
        .halted_o     (halted_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rd,
                                    input reg_addr_t rs1, input reg_addr_t rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic void clear_program();
        prog_len = 0;
    endfunction

    function automatic void push_inst(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    // reference behavior up to the first ecall
    function automatic void model_run();
        word_t w;
        word_t a;
        word_t b;
        word_t imm;
        for (int pc = 0; pc < prog_len; pc++) begin
            w = prog[pc];
            if (w == ECALL_WORD) begin
                break;
            end
            a   = model_rf[w[19:15]];
            b   = model_rf[w[24:20]];
            imm = {{20{w[31]}}, w[31:20]};
            if (w[11:7] != 5'd0 && w[14:12] == 3'b000) begin
                if (w[6:0] == 7'b0010011) begin
                    model_rf[w[11:7]] = a + imm;
                end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0000000) begin
                    model_rf[w[11:7]] = a + b;
                end else if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000) begin
                    model_rf[w[11:7]] = a - b;   // rs1 - rs2
                end
            end
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("[ERROR] %0t: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk_i);
            imem_we_i    <= 1'b1;
            imem_waddr_i <= imem_addr_t'(i);
            imem_wdata_i <= prog[i];
        end
        @(posedge clk_i);
        imem_we_i <= 1'b0;
    endtask

    task automatic run_until_halt(output bit ok);
        int cyc;
        ok = 1'b0;
        cyc = 0;
        @(posedge clk_i);
        start_i <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        @(negedge clk_i);
        check_value(halted_o, 1'b0, "halted_o right after start");
        while (!halted_o && cyc < RUN_TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (halted_o) begin
            ok = 1'b1;
        end else begin
            timeout_cnt++;
            $display("timeout: core did not halt within %0d cycles at %0t",
                     RUN_TIMEOUT, $time);
        end
    endtask

    task automatic compare_regs(input string tag);
        for (int r = 0; r < `REG_NUM; r++) begin
            @(posedge clk_i);
            dbg_raddr_i <= reg_addr_t'(r);
            @(negedge clk_i);
            check_value(dbg_rdata_o, model_rf[r], $sformatf("%s x%0d", tag, r));
        end
    endtask

    task automatic execute_and_compare(input string tag);
        bit ok;
        load_program();
        model_run();
        run_until_halt(ok);
        if (ok) begin
            compare_regs(tag);
        end
    endtask

    task automatic addi_chain();
        clear_program();
        push_inst(enc_i(3'b000, 5'd1, 5'd0, 12'd5));
        push_inst(enc_i(3'b000, 5'd2, 5'd1, 12'hFFD));    // -3
        push_inst(enc_i(3'b000, 5'd3, 5'd2, 12'h7FF));    // largest positive
        push_inst(enc_i(3'b000, 5'd4, 5'd0, 12'h800));    // -2048
        push_inst(enc_i(3'b000, 5'd5, 5'd4, 12'hFFF));
        push_inst(enc_i(3'b000, 5'd1, 5'd1, 12'd100));
        push_inst(ECALL_WORD);
        execute_and_compare("addi chain");
    endtask

    task automatic dependent_add_sub();
        clear_program();
        push_inst(enc_i(3'b000, 5'd6, 5'd0, 12'd7));
        push_inst(enc_r(7'b0000000, 5'd7, 5'd6, 5'd6));
        push_inst(enc_r(7'b0100000, 5'd8, 5'd7, 5'd6));
        push_inst(enc_r(7'b0100000, 5'd9, 5'd6, 5'd8));   // result zero
        push_inst(enc_r(7'b0100000, 5'd10, 5'd9, 5'd7));  // negative
        push_inst(enc_r(7'b0000000, 5'd10, 5'd10, 5'd3));
        push_inst(enc_r(7'b0100000, 5'd11, 5'd0, 5'd10));
        push_inst(ECALL_WORD);
        execute_and_compare("add/sub chain");
    endtask

    task automatic x0_write_attempts();
        clear_program();
        push_inst(enc_i(3'b000, 5'd0, 5'd1, 12'd55));
        push_inst(enc_r(7'b0000000, 5'd0, 5'd1, 5'd2));
        push_inst(enc_r(7'b0100000, 5'd0, 5'd3, 5'd1));
        push_inst(enc_i(3'b000, 5'd12, 5'd0, 12'd1)); // must not see forwarded x0
        push_inst(ECALL_WORD);
        execute_and_compare("x0 writes");
    endtask

    task automatic unsupported_encodings();
        clear_program();
        push_inst(enc_i(3'b100, 5'd13, 5'd1, 12'd5));         // xori
        push_inst({12'd5, 5'd1, 3'b000, 5'd14, 7'b0001011});  // custom opcode
        push_inst(enc_r(7'b0000001, 5'd15, 5'd1, 5'd2));
        push_inst(ECALL_WORD);
        push_inst(enc_i(3'b000, 5'd16, 5'd0, 12'd99));
        push_inst(enc_r(7'b0000000, 5'd17, 5'd1, 5'd1));
        execute_and_compare("unsupported");
    endtask

    task automatic random_program();
        logic [31:0] r;
        clear_program();
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            case (r[31:30])
                2'd1: push_inst(enc_r(7'b0000000, r[4:0], r[9:5], r[14:10]));
                2'd2: push_inst(enc_r(7'b0100000, r[4:0], r[9:5], r[14:10]));
                default: push_inst(enc_i(3'b000, r[4:0], r[9:5], r[26:15]));
            endcase
        end
        push_inst(ECALL_WORD);
        execute_and_compare("random");
    endtask

    task automatic restart_after_halt();
        @(negedge clk_i);
        check_value(halted_o, 1'b1, "halted_o before restart");
        clear_program();
        push_inst(enc_i(3'b000, 5'd1, 5'd0, 12'h123));
        push_inst(enc_r(7'b0100000, 5'd2, 5'd1, 5'd31));
        push_inst(ECALL_WORD);
        execute_and_compare("restart");
        @(negedge clk_i);
        check_value(halted_o, 1'b1, "halted_o after restart");
    endtask

    initial begin
        arst_n_i     = 1'b0;
        start_i      = 1'b0;
        imem_we_i    = 1'b0;
        imem_waddr_i = '0;
        imem_wdata_i = '0;
        dbg_raddr_i  = '0;
        rng_state    = 32'd44900;
        prog_len     = 0;
        check_cnt    = 0;
        err_cnt      = 0;
        timeout_cnt  = 0;
        for (int r = 0; r < `REG_NUM; r++) begin
            model_rf[r] = '0;
        end

        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value(halted_o, 1'b0, "halted_o after reset");

        addi_chain();
        dependent_add_sub();
        x0_write_attempts();
        unsupported_encodings();
        random_program();
        restart_after_halt();

        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
imem.sv
regs.sv
id.sv
ex.sv
core_ctrl.sv
rv_core_top.sv
rv_core_sva.sv
tb_rv_core.sv
